/* ide_disk.f */
ide_disk_pkg.sv
ide_bus_decode.sv
ide_task_file.sv
ide_command_ctrl.sv
ide_sector_buffer.sv
ide_read_response.sv
ide_disk.sv
ide_disk_checker.sv
tb_ide_disk.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the ide disk testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f ide_disk.f --top-module tb_ide_disk -o sim_ide_disk
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/sim_ide_disk > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -qx "all tests passed" "$log"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see $log"
   exit 1
fi

/* tb_ide_disk.sv */
// ide disk testbench: table-driven register and sector transfers checked against a shadow model
module tb_ide_disk
   import ide_disk_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   typedef enum logic [1:0] {K_WR, K_RD, K_RDB} kind_e;    // K_RDB reads run back to back

   logic        ide_dior;
   logic        rst_n;
   logic [1:0]  ide_cs;
   logic [2:0]  ide_da;
   logic [15:0] ide_data_in;
   logic        ide_rd;
   logic        ide_wr;
   logic [15:0] ide_data_out;

   kind_e       tbl_kind [$];
   logic [4:0]  tbl_addr [$];
   logic [15:0] tbl_data [$];
   logic [15:0] tbl_exp [$];
   logic [15:0] shadow [1024];
   logic [31:0] rnd;
   int          errors;
   int          checks;
   bit          table_ready;

   ide_disk dut (
      .ide_dior     (ide_dior),
      .rst_n        (rst_n),
      .ide_cs       (ide_cs),
      .ide_da       (ide_da),
      .ide_data_in  (ide_data_in),
      .ide_rd       (ide_rd),
      .ide_wr       (ide_wr),
      .ide_data_out (ide_data_out)
   );

   always #50 ide_dior = ~ide_dior;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check(input string msg, input logic [15:0] got, input logic [15:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[ERROR] %0d ns: %s: got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic add_entry(input kind_e k, input logic [4:0] a, input logic [15:0] d,
                            input logic [15:0] e);
      tbl_kind.push_back(k);
      tbl_addr.push_back(a);
      tbl_data.push_back(d);
      tbl_exp.push_back(e);
   endtask

   task automatic set_task_file(input int lba, input int cnt);
      add_entry(K_WR, ATA_SECCNT, 16'(cnt), 16'h0000);
      add_entry(K_WR, ATA_SECNUM, 16'(lba & 'hff), 16'h0000);
      add_entry(K_WR, ATA_CYLLOW, 16'((lba >> 8) & 'hff), 16'h0000);
      add_entry(K_WR, ATA_CYLHIGH, 16'((lba >> 16) & 'hff), 16'h0000);
      add_entry(K_WR, ATA_DRVHEAD, 16'h00e0 | 16'((lba >> 24) & 'hf), 16'h0000);    // lba mode
   endtask

   // full sector transfer, sector position wraps modulo four
   task automatic add_transfer(input int lba, input int cnt, input bit is_write, input bit burst);
      int base;
      int idx;
      int i;
      base = (lba % 4) * 256;
      set_task_file(lba, cnt);
      add_entry(K_WR, ATA_COMMAND, is_write ? 16'h0030 : 16'h0020, 16'h0000);
      add_entry(K_RD, ATA_STATUS, 16'h0000, 16'h0058);
      add_entry(K_RD, ATA_ERROR, 16'h0000, 16'h0000);
      for (i = 0; i < cnt * 256; i++)
      begin
         idx = (base + i) % 1024;
         if (is_write)
         begin
            rnd = xorshift32(rnd);
            shadow[idx[9:0]] = rnd[15:0];
            add_entry(K_WR, ATA_DATA, rnd[15:0], 16'h0000);
         end
         else if (burst)
            add_entry(K_RDB, ATA_DATA, 16'h0000, shadow[idx[9:0]]);
         else
            add_entry(K_RD, ATA_DATA, 16'h0000, shadow[idx[9:0]]);
      end
      add_entry(K_RD, ATA_STATUS, 16'h0000, 16'h0050);
   endtask

   task automatic add_abort(input logic [15:0] cmd);
      add_entry(K_WR, ATA_COMMAND, cmd, 16'h0000);
      add_entry(K_RD, ATA_STATUS, 16'h0000, 16'h0051);
      add_entry(K_RD, ATA_ERROR, 16'h0000, 16'h0004);
   endtask

   task automatic build_table();
      add_entry(K_RD, ATA_STATUS, 16'h0000, 16'h0050);
      add_entry(K_RD, ATA_ERROR, 16'h0000, 16'h0000);
      add_entry(K_WR, ATA_DEVCTRL, 16'h0002, 16'h0000);    // ignored
      add_transfer(2, 1, 1'b1, 1'b0);
      add_transfer(2, 1, 1'b0, 1'b0);
      add_transfer(3, 2, 1'b1, 1'b0);                      // second sector lands in sector 0
      add_transfer(0, 1, 1'b0, 1'b0);
      set_task_file(1, 1);
      add_abort(16'h00ec);
      add_entry(K_WR, ATA_COMMAND, 16'h0020, 16'h0000);
      add_entry(K_RD, ATA_STATUS, 16'h0000, 16'h0058);
      add_entry(K_RD, ATA_ERROR, 16'h0000, 16'h0000);
      add_entry(K_WR, ATA_SECCNT, 16'h0000, 16'h0000);
      add_abort(16'h0020);
      add_entry(K_WR, ATA_SECCNT, 16'h0005, 16'h0000);
      add_abort(16'h0030);
      add_transfer(1, 1, 1'b1, 1'b0);
      add_entry(K_RD, ATA_DATA, 16'h0000, 16'h0000);       // no transfer active
      add_transfer(2, 1, 1'b0, 1'b1);
   endtask

   task automatic drive_access(input kind_e k, input logic [4:0] a, input logic [15:0] d);
      @(posedge ide_dior);
      {ide_cs, ide_da} <= a;
      ide_data_in <= d;
      ide_wr <= (k == K_WR);
      ide_rd <= (k != K_WR);
   endtask

   task automatic drive_idle();
      @(posedge ide_dior);
      ide_rd <= 1'b0;
      ide_wr <= 1'b0;
   endtask

   task automatic apply_spaced(input int i);
      drive_access(tbl_kind[i], tbl_addr[i], tbl_data[i]);
      drive_idle();
      repeat (3) @(posedge ide_dior);
      @(negedge ide_dior);
      if (tbl_kind[i] == K_RD)
         check($sformatf("entry %0d read of reg %h", i, tbl_addr[i]), ide_data_out, tbl_exp[i]);
   endtask

   // one read per cycle, results trail the strobes by four edges
   task automatic apply_burst(input int first, input int n);
      int c;
      for (c = 0; c < n + 4; c++)
      begin
         if (c < n)
            drive_access(K_RD, ATA_DATA, 16'h0000);
         else
            drive_idle();
         @(negedge ide_dior);
         if (c >= 4)
            check($sformatf("entry %0d burst data read", first + c - 4), ide_data_out,
                  tbl_exp[first + c - 4]);
      end
   endtask

   initial
   begin
      wait (table_ready);
      repeat (tbl_kind.size() * 8 + 100) @(posedge ide_dior);
      $display("timeout: the test table did not finish in the allowed number of cycles");
      $display("tests failed");
      $finish;
   end

   initial
   begin
      int i;
      int n;
      int fails;
      ide_dior = 1'b0;
      rst_n = 1'b0;
      ide_cs = 2'b00;
      ide_da = 3'b000;
      ide_data_in = 16'h0000;
      ide_rd = 1'b0;
      ide_wr = 1'b0;
      errors = 0;
      checks = 0;
      rnd = 32'ha378_8d5d;
      build_table();
      table_ready = 1'b1;
      repeat (4) @(posedge ide_dior);
      rst_n <= 1'b1;
      i = 0;
      while (i < tbl_kind.size())
      begin
         if (tbl_kind[i] == K_RDB)
         begin
            n = 0;
            while ((i + n) < tbl_kind.size() && tbl_kind[i + n] == K_RDB)
               n++;
            apply_burst(i, n);
            i = i + n;
         end
         else
         begin
            apply_spaced(i);
            i++;
         end
      end
      repeat (2) @(posedge ide_dior);
      fails = dut.u_checker.fails;
      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, fails);
      if (errors == 0 && fails == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

/* ide_disk_checker.sv */
// ide disk checker: assertions on read output timing, buffer write enables and reset values
module ide_disk_checker
   import ide_disk_pkg::*;
(
   input logic        ide_dior,
   input logic        rst_n,
   input logic        acc_rd,
   input logic        acc_wr,
   input logic        buf_we,
   input ctrl_state_e state,
   input logic [15:0] ide_data_out
);
   timeunit 1ns;
   timeprecision 100ps;

   int fails = 0;

   // output only moves as a read leaves the pipeline
   property data_out_after_read;
      @(posedge ide_dior) disable iff (!rst_n)
         $changed(ide_data_out) |-> $past(acc_rd, 3);
   endproperty

   property write_only_in_transfer;
      @(posedge ide_dior) disable iff (!rst_n)
         $rose(buf_we) |-> ($past(state) == ST_WRITE_XFER);
   endproperty

   property reset_clears;
      @(posedge ide_dior)
         !rst_n |=> (ide_data_out == 16'h0000) && !buf_we && !acc_rd && !acc_wr;
   endproperty

   a_data_out: assert property (data_out_after_read)
   else
   begin
      $error("ide_data_out changed without a read three cycles earlier");
      fails++;
   end

   a_buf_we: assert property (write_only_in_transfer)
   else
   begin
      $error("buf_we rose outside a write transfer");
      fails++;
   end

   a_reset: assert property (reset_clears)
   else
   begin
      $error("outputs not cleared after reset");
      fails++;
   end

endmodule

bind ide_disk ide_disk_checker u_checker (
   .ide_dior     (ide_dior),
   .rst_n        (rst_n),
   .acc_rd       (acc_rd),
   .acc_wr       (acc_wr),
   .buf_we       (buf_we),
   .state        (u_command_ctrl.state),
   .ide_data_out (ide_data_out)
);

/* ide_disk.sv */
// ide disk target top: bus decode, task file and control, sector buffer, read response
module ide_disk
   import ide_disk_pkg::*;
(
   input  logic        ide_dior,
   input  logic        rst_n,
   input  logic [1:0]  ide_cs,
   input  logic [2:0]  ide_da,
   input  logic [15:0] ide_data_in,
   input  logic        ide_rd,
   input  logic        ide_wr,
   output logic [15:0] ide_data_out
);

   logic                  acc_rd;
   logic                  acc_wr;
   ata_reg_e              acc_sel;
   logic [15:0]           acc_data;
   logic [27:0]           lba;
   logic [7:0]            seccnt;
   logic                  buf_we;
   logic [BUF_ADDR_W-1:0] buf_addr;
   logic [15:0]           buf_wdata;
   logic                  resp_rd;
   ata_reg_e              resp_sel;
   logic [7:0]            status;
   logic [7:0]            error;
   logic [15:0]           buf_rdata;
   logic                  resp_rd_d;
   ata_reg_e              resp_sel_d;
   logic [7:0]            status_d;
   logic [7:0]            error_d;

   ide_bus_decode u_bus_decode (
      .ide_dior    (ide_dior),
      .rst_n       (rst_n),
      .ide_cs      (ide_cs),
      .ide_da      (ide_da),
      .ide_data_in (ide_data_in),
      .ide_rd      (ide_rd),
      .ide_wr      (ide_wr),
      .acc_rd      (acc_rd),
      .acc_wr      (acc_wr),
      .acc_sel     (acc_sel),
      .acc_data    (acc_data)
   );

   ide_task_file u_task_file (
      .ide_dior (ide_dior),
      .rst_n    (rst_n),
      .acc_wr   (acc_wr),
      .acc_sel  (acc_sel),
      .acc_data (acc_data),
      .lba      (lba),
      .seccnt   (seccnt)
   );

   ide_command_ctrl u_command_ctrl (
      .ide_dior  (ide_dior),
      .rst_n     (rst_n),
      .acc_rd    (acc_rd),
      .acc_wr    (acc_wr),
      .acc_sel   (acc_sel),
      .acc_data  (acc_data),
      .lba       (lba),
      .seccnt    (seccnt),
      .buf_we    (buf_we),
      .buf_addr  (buf_addr),
      .buf_wdata (buf_wdata),
      .resp_rd   (resp_rd),
      .resp_sel  (resp_sel),
      .status    (status),
      .error     (error)
   );

   ide_sector_buffer u_sector_buffer (
      .ide_dior   (ide_dior),
      .buf_we     (buf_we),
      .buf_addr   (buf_addr),
      .buf_wdata  (buf_wdata),
      .resp_rd    (resp_rd),
      .resp_sel   (resp_sel),
      .status     (status),
      .error      (error),
      .buf_rdata  (buf_rdata),
      .resp_rd_d  (resp_rd_d),
      .resp_sel_d (resp_sel_d),
      .status_d   (status_d),
      .error_d    (error_d)
   );

   ide_read_response u_read_response (
      .ide_dior     (ide_dior),
      .rst_n        (rst_n),
      .buf_rdata    (buf_rdata),
      .resp_rd_d    (resp_rd_d),
      .resp_sel_d   (resp_sel_d),
      .status_d     (status_d),
      .error_d      (error_d),
      .ide_data_out (ide_data_out)
   );

endmodule

/* ide_read_response.sv */
// ide read response: loads buffer data, status or error onto the host data output
module ide_read_response
   import ide_disk_pkg::*;
(
   input  logic        ide_dior,
   input  logic        rst_n,
   input  logic [15:0] buf_rdata,
   input  logic        resp_rd_d,
   input  ata_reg_e    resp_sel_d,
   input  logic [7:0]  status_d,
   input  logic [7:0]  error_d,
   output logic [15:0] ide_data_out
);

   logic [15:0] rd_data;

   always_comb
   begin
      case (resp_sel_d)
         ATA_DATA:
            rd_data = buf_rdata;    // legal transfer read only
         ATA_STATUS:
            rd_data = {8'h00, status_d};
         ATA_ERROR:
            rd_data = {8'h00, error_d};
         default:
            rd_data = 16'h0000;
      endcase
   end

   always_ff @(posedge ide_dior)
   begin
      if (!rst_n)
         ide_data_out <= 16'h0000;
      else if (resp_rd_d)
         ide_data_out <= rd_data;    // held between reads
   end

endmodule

/* ide_sector_buffer.sv */
// ide sector buffer: four-sector word RAM, read-first registered port, response tag kept aligned
module ide_sector_buffer
   import ide_disk_pkg::*;
(
   input  logic                  ide_dior,
   input  logic                  buf_we,
   input  logic [BUF_ADDR_W-1:0] buf_addr,
   input  logic [15:0]           buf_wdata,
   input  logic                  resp_rd,
   input  ata_reg_e              resp_sel,
   input  logic [7:0]            status,
   input  logic [7:0]            error,
   output logic [15:0]           buf_rdata,
   output logic                  resp_rd_d,
   output ata_reg_e              resp_sel_d,
   output logic [7:0]            status_d,
   output logic [7:0]            error_d
);

   logic [15:0] mem [BUF_WORDS];

   always_ff @(posedge ide_dior)
   begin
      if (buf_we)
         mem[buf_addr] <= buf_wdata;
      buf_rdata <= mem[buf_addr];    // old data on a same-cycle write
   end

   // tag rides along with the ram read
   always_ff @(posedge ide_dior)
   begin
      resp_rd_d  <= resp_rd;
      resp_sel_d <= resp_sel;
      status_d   <= status;
      error_d    <= error;
   end

endmodule

/* ide_command_ctrl.sv */
// ide command controller: command FSM, status and error registers, transfer addressing
module ide_command_ctrl
   import ide_disk_pkg::*;
(
   input  logic                  ide_dior,
   input  logic                  rst_n,
   input  logic                  acc_rd,
   input  logic                  acc_wr,
   input  ata_reg_e              acc_sel,
   input  logic [15:0]           acc_data,
   input  logic [27:0]           lba,
   input  logic [7:0]            seccnt,
   output logic                  buf_we,
   output logic [BUF_ADDR_W-1:0] buf_addr,
   output logic [15:0]           buf_wdata,
   output logic                  resp_rd,
   output ata_reg_e              resp_sel,
   output logic [7:0]            status,
   output logic [7:0]            error
);

   ctrl_state_e           state;
   logic [BUF_ADDR_W:0]   word_cnt;    // words left, up to a full buffer
   logic [BUF_ADDR_W-1:0] base_addr;
   logic [BUF_ADDR_W-1:0] offset;
   logic                  cmd_wr;
   logic                  cmd_ok;
   logic                  data_rd_ok;
   logic                  data_wr_ok;

   assign cmd_wr = acc_wr && (acc_sel == ATA_COMMAND);
   assign cmd_ok = ((acc_data[7:0] == CMD_READ) || (acc_data[7:0] == CMD_WRITE))
                   && (seccnt != 8'h00) && (seccnt <= MAX_SECTORS);

   assign data_rd_ok = acc_rd && (acc_sel == ATA_DATA) && (state == ST_READ_XFER);
   assign data_wr_ok = acc_wr && (acc_sel == ATA_DATA) && (state == ST_WRITE_XFER);

   always_ff @(posedge ide_dior)
   begin
      if (!rst_n)
      begin
         state     <= ST_IDLE;
         status    <= STATUS_DRDY | STATUS_DSC;
         error     <= 8'h00;
         word_cnt  <= '0;
         base_addr <= '0;
         offset    <= '0;
         buf_we    <= 1'b0;
         buf_addr  <= '0;
         resp_rd   <= 1'b0;
         resp_sel  <= REG_NONE;
      end
      else
      begin
         if (cmd_wr && cmd_ok)
         begin
            state     <= (acc_data[7:0] == CMD_READ) ? ST_READ_XFER : ST_WRITE_XFER;
            status    <= STATUS_DRDY | STATUS_DSC | STATUS_DRQ;
            error     <= 8'h00;
            word_cnt  <= (BUF_ADDR_W+1)'(seccnt * WORDS_PER_SECTOR);
            base_addr <= BUF_ADDR_W'(lba[1:0] * WORDS_PER_SECTOR);
            offset    <= '0;
         end
         else if (cmd_wr)
         begin
            state  <= ST_IDLE;    // unknown opcode or bad count
            status <= STATUS_DRDY | STATUS_DSC | STATUS_ERR;
            error  <= ERROR_ABRT;
         end
         else if (data_rd_ok || data_wr_ok)
         begin
            offset   <= offset + 1'b1;
            word_cnt <= word_cnt - 1'b1;
            if (word_cnt == 1)
            begin
               state  <= ST_IDLE;
               status <= STATUS_DRDY | STATUS_DSC;
            end
         end

         buf_we   <= data_wr_ok;
         buf_addr <= base_addr + offset;    // wraps at buffer end
         resp_rd  <= acc_rd;
         // stray data reads answer zero
         resp_sel <= (acc_sel == ATA_DATA && !data_rd_ok) ? REG_NONE : acc_sel;
      end
   end

   always_ff @(posedge ide_dior)
      buf_wdata <= acc_data;

endmodule

/* ide_task_file.sv */
// ide task file: holds sector count, sector number, cylinder and drive/head, presents the lba
module ide_task_file
   import ide_disk_pkg::*;
(
   input  logic        ide_dior,
   input  logic        rst_n,
   input  logic        acc_wr,
   input  ata_reg_e    acc_sel,
   input  logic [15:0] acc_data,
   output logic [27:0] lba,
   output logic [7:0]  seccnt
);

   logic [7:0] seccnt_r;
   logic [7:0] secnum_r;
   logic [7:0] cyllow_r;
   logic [7:0] cylhigh_r;
   logic [3:0] head_r;    // only the lba nibble, single drive

   always_ff @(posedge ide_dior)
   begin
      if (!rst_n)
      begin
         seccnt_r  <= 8'h00;
         secnum_r  <= 8'h00;
         cyllow_r  <= 8'h00;
         cylhigh_r <= 8'h00;
         head_r    <= 4'h0;
      end
      else if (acc_wr)
      begin
         case (acc_sel)
            ATA_SECCNT:
               seccnt_r <= acc_data[7:0];
            ATA_SECNUM:
               secnum_r <= acc_data[7:0];
            ATA_CYLLOW:
               cyllow_r <= acc_data[7:0];
            ATA_CYLHIGH:
               cylhigh_r <= acc_data[7:0];
            ATA_DRVHEAD:
               head_r <= acc_data[3:0];
            // accepted, no effect
            ATA_FEATURE, ATA_ALTER, ATA_DEVCTRL:
            begin
            end
            default:
            begin
            end
         endcase
      end
   end

   // lba28: head nibble, cyl high, cyl low, sector number
   assign lba    = {head_r, cylhigh_r, cyllow_r, secnum_r};
   assign seccnt = seccnt_r;

endmodule

/* ide_bus_decode.sv */
// ide bus decode: registers the host bus and turns cs/da into a register select and access strobes
module ide_bus_decode
   import ide_disk_pkg::*;
(
   input  logic        ide_dior,
   input  logic        rst_n,
   input  logic [1:0]  ide_cs,
   input  logic [2:0]  ide_da,
   input  logic [15:0] ide_data_in,
   input  logic        ide_rd,
   input  logic        ide_wr,
   output logic        acc_rd,
   output logic        acc_wr,
   output ata_reg_e    acc_sel,
   output logic [15:0] acc_data
);

   logic [4:0] addr;
   ata_reg_e   sel_d;
   logic       hit;

   assign addr = {ide_cs, ide_da};

   always_comb
   begin
      case (addr)
         ATA_ALTER, ATA_DATA, ATA_ERROR, ATA_SECCNT, ATA_SECNUM,
         ATA_CYLLOW, ATA_CYLHIGH, ATA_DRVHEAD, ATA_STATUS, ATA_DEVCTRL:
            sel_d = ata_reg_e'(addr);
         default:
            sel_d = REG_NONE;
      endcase
   end

   assign hit = (sel_d != REG_NONE);

   always_ff @(posedge ide_dior)
   begin
      if (!rst_n)
      begin
         acc_rd  <= 1'b0;
         acc_wr  <= 1'b0;
         acc_sel <= REG_NONE;
      end
      else
      begin
         acc_rd  <= ide_rd & ~ide_wr & hit;    // write wins when both strobes set
         acc_wr  <= ide_wr & hit;
         acc_sel <= sel_d;
      end
   end

   always_ff @(posedge ide_dior)
      acc_data <= ide_data_in;

endmodule

/* ide_disk_pkg.sv */
// ide disk shared types: register map, commands, controller states, status bits, buffer sizes
package ide_disk_pkg;

   // {cs, da} register addresses, one name per address
   typedef enum logic [4:0]
   {
      REG_NONE    = 5'h00,    // no register selected
      ATA_ALTER   = 5'h0e,
      ATA_DATA    = 5'h10,
      ATA_ERROR   = 5'h11,
      ATA_SECCNT  = 5'h12,
      ATA_SECNUM  = 5'h13,
      ATA_CYLLOW  = 5'h14,
      ATA_CYLHIGH = 5'h15,
      ATA_DRVHEAD = 5'h16,
      ATA_STATUS  = 5'h17,
      ATA_DEVCTRL = 5'h1e
   } ata_reg_e;

   // write-direction names of the shared addresses
   localparam ata_reg_e ATA_FEATURE = ATA_ERROR;
   localparam ata_reg_e ATA_COMMAND = ATA_STATUS;

   typedef enum logic [7:0]
   {
      CMD_READ  = 8'h20,
      CMD_WRITE = 8'h30
   } ata_cmd_e;

   typedef enum logic [1:0]
   {
      ST_IDLE,
      ST_READ_XFER,
      ST_WRITE_XFER
   } ctrl_state_e;

   localparam logic [7:0] STATUS_DRDY = 8'h40;
   localparam logic [7:0] STATUS_DSC  = 8'h10;
   localparam logic [7:0] STATUS_DRQ  = 8'h08;
   localparam logic [7:0] STATUS_ERR  = 8'h01;

   localparam logic [7:0] ERROR_ABRT = 8'h04;    // command aborted

   // four sectors of 256 words, sector index from lba[1:0]
   localparam int BUF_WORDS        = 1024;
   localparam int WORDS_PER_SECTOR = 256;
   localparam int MAX_SECTORS      = 4;
   localparam int BUF_ADDR_W       = 10;

endpackage
